// ==== design/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

//////////////////////////////
// address widths
//////////////////////////////
`define FETCH_VA_W      32
`define FETCH_LINE_W    28      // 16-byte line number
`define FETCH_PFN_W     12      // physical frame
`define FETCH_PA_W      24

// field widths derived from the above
`define FETCH_BYTE_W    (`FETCH_VA_W - `FETCH_LINE_W)
`define FETCH_PGOFF_W   12      // 4 KB pages
`define FETCH_VPN_W     (`FETCH_VA_W - `FETCH_PGOFF_W)
`define FETCH_PLINE_W   (`FETCH_PA_W - `FETCH_BYTE_W)

//////////////////////////////
// tlb and cache geometry
//////////////////////////////
`define FETCH_TLB_N     8
`define FETCH_TLB_IDX_W 3

`define FETCH_SETS      16      // per bank
`define FETCH_SET_W     4
`define FETCH_LINE_BITS 128

`endif

// ==== design/fetch_pkg.sv ====
`default_nettype none
`include "fetch_consts.svh"

package fetch_pkg;

    // one fetch address, decoded by the tlb and by the fetch path
    typedef struct packed {
        logic [`FETCH_VPN_W-1:0]   vpn;
        logic [`FETCH_PGOFF_W-1:0] offset;
    } va_page_t;

    typedef struct packed {
        logic [`FETCH_LINE_W-1:0] lnum;
        logic [`FETCH_BYTE_W-1:0] byte_sel;
    } va_line_t;

    typedef union packed {
        va_page_t page;     // tlb view
        va_line_t line;     // fetch register and cache view
    } fetch_va_u;

    typedef struct packed {
        logic      valid;
        fetch_va_u addr;
    } redirect_t;

    typedef struct packed {
        logic                    valid;
        logic                    present;
        logic                    pcd;       // uncached device page
        logic [`FETCH_VPN_W-1:0] vpn;
        logic [`FETCH_PFN_W-1:0] pfn;
    } tlb_entry_t;

    typedef struct packed {
        logic                        we;
        logic [`FETCH_TLB_IDX_W-1:0] idx;
        tlb_entry_t                  entry;
    } tlb_wr_t;

    typedef struct packed {
        logic                    hit;
        logic                    miss;
        logic                    fault;
        logic [`FETCH_PFN_W-1:0] pfn;
    } xlate_t;

    typedef struct packed {
        logic miss;
        logic fault;
    } fetch_status_t;

    // fill port, one-cycle strobes
    typedef struct packed {
        logic                      valid;
        logic [`FETCH_PLINE_W-1:0] pline;
    } fill_req_t;

    typedef struct packed {
        logic                        valid;
        logic [`FETCH_PLINE_W-1:0]   pline;
        logic [`FETCH_LINE_BITS-1:0] data;
    } fill_rsp_t;

    typedef struct packed {
        logic                        valid;
        logic [`FETCH_LINE_W-1:0]    vline;
        logic [`FETCH_LINE_BITS-1:0] data;
    } fetch_line_t;

endpackage

`default_nettype wire

// ==== design/fetch_addr_select.sv ====
`default_nettype none
`include "fetch_consts.svh"

module fetch_addr_select #(
    parameter int PARITY = 0        // 0 even bank, 1 odd bank
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n_i,
    input  wire fetch_pkg::redirect_t     init_i,
    input  wire fetch_pkg::redirect_t     resteer_i,
    input  wire fetch_pkg::redirect_t     predict_i,
    input  wire logic                     consume_i,
    output logic [`FETCH_LINE_W-1:0]      line_o
);

    localparam int LW = `FETCH_LINE_W;

    fetch_pkg::redirect_t sel_redirect;
    logic                 redirect;
    logic                 split_inc;
    logic [LW-1:0]        split_line;
    logic [LW-1:0]        line_q;

    //////////////////////////////
    // redirect priority
    //////////////////////////////
    assign redirect = init_i.valid | resteer_i.valid | predict_i.valid;

    always_comb begin
        if (init_i.valid) begin
            sel_redirect = init_i;
        end else if (resteer_i.valid) begin
            sel_redirect = resteer_i;
        end else begin
            sel_redirect = predict_i;      // also the idle default
        end
    end

    // bit 4 of the address is lnum[0]
    // this bank takes line+1 when the addressed line has the other parity
    assign split_inc  = sel_redirect.addr.line.lnum[0] ^ 1'(PARITY);
    assign split_line = sel_redirect.addr.line.lnum + {{(LW-1){1'b0}}, split_inc};

    //////////////////////////////
    // fetch address register
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            line_q <= LW'(PARITY);               // 0 even, 1 odd
        end else if (redirect) begin
            line_q <= split_line;                // redirect beats consume
        end else if (consume_i) begin
            line_q <= line_q + LW'(2);           // next line of same parity
        end
    end

    assign line_o = line_q;

endmodule

`default_nettype wire

// ==== design/fetch_tlb.sv ====
`default_nettype none
`include "fetch_consts.svh"

module fetch_tlb (
    input  wire logic                 clk,
    input  wire logic                 arst_n_i,
    input  wire fetch_pkg::tlb_wr_t   tlb_wr_i,
    input  wire logic [`FETCH_LINE_W-1:0] line_i,
    output fetch_pkg::xlate_t         xlate_o
);

    localparam int N  = `FETCH_TLB_N;
    localparam int IW = `FETCH_TLB_IDX_W;

    fetch_pkg::tlb_entry_t entry_q [N];
    logic [N-1:0]          valid_q;
    fetch_pkg::fetch_va_u  va;
    logic [N-1:0]          match;
    logic [IW-1:0]         hit_idx;
    logic                  found;

    //////////////////////////////
    // software write port
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (tlb_wr_i.we) begin
            valid_q[tlb_wr_i.idx] <= tlb_wr_i.entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_wr_i.we) begin
            entry_q[tlb_wr_i.idx] <= tlb_wr_i.entry;
        end
    end

    //////////////////////////////
    // lookup
    //////////////////////////////
    assign va = {line_i, {`FETCH_BYTE_W{1'b0}}};

    always_comb begin
        for (int i = 0; i < N; i++) begin
            match[i] = valid_q[i] & entry_q[i].present & (entry_q[i].vpn == va.page.vpn);
        end
    end

    // walk down so the lowest matching index is left in hit_idx
    always_comb begin
        hit_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = IW'(i);
            end
        end
    end

    assign found = |match;

    assign xlate_o.miss  = ~found;
    assign xlate_o.fault = found & entry_q[hit_idx].pcd;    // no fetch from device pages
    assign xlate_o.hit   = found & ~entry_q[hit_idx].pcd;
    assign xlate_o.pfn   = found ? entry_q[hit_idx].pfn : '0;

endmodule

`default_nettype wire

// ==== design/icache_bank.sv ====
`default_nettype none
`include "fetch_consts.svh"

module icache_bank (
    input  wire logic                     clk,
    input  wire logic                     arst_n_i,
    input  wire logic [`FETCH_LINE_W-1:0] line_i,
    input  wire fetch_pkg::xlate_t        xlate_i,
    input  wire fetch_pkg::fill_rsp_t     fill_rsp_i,
    output fetch_pkg::fill_req_t          fill_req_o,
    output fetch_pkg::fetch_line_t        line_o,
    output fetch_pkg::fetch_status_t      status_o
);

    localparam int PLW   = `FETCH_PLINE_W;
    localparam int SW    = `FETCH_SET_W;
    localparam int TAG_W = PLW - SW - 1;      // bit 0 is the bank select

    // line store
    logic [`FETCH_LINE_BITS-1:0] data_mem [`FETCH_SETS];
    logic [TAG_W-1:0]            tag_mem  [`FETCH_SETS];
    logic [`FETCH_SETS-1:0]      valid_q;

    fetch_pkg::fetch_va_u     va;
    logic [PLW-1:0]           pline;
    logic [SW-1:0]            set_idx;
    logic [SW-1:0]            fill_set;
    logic                     cur_hit;
    logic                     cur_miss;
    logic                     req_fire;

    // registered lookup
    logic                        hit_q;
    logic                        miss_q;
    logic [PLW-1:0]              miss_pline_q;
    logic [`FETCH_LINE_W-1:0]    vline_q;
    logic [`FETCH_LINE_BITS-1:0] data_q;
    fetch_pkg::fetch_status_t    status_q;
    logic                        pend_q;
    logic                        req_q;
    logic [PLW-1:0]              req_pline_q;

    //////////////////////////////
    // address split
    //////////////////////////////
    assign va       = {line_i, {`FETCH_BYTE_W{1'b0}}};
    assign pline    = {xlate_i.pfn, va.page.offset[`FETCH_PGOFF_W-1:`FETCH_BYTE_W]};
    assign set_idx  = pline[SW:1];
    assign fill_set = fill_rsp_i.pline[SW:1];

    assign cur_hit  = xlate_i.hit & valid_q[set_idx] & (tag_mem[set_idx] == pline[PLW-1:SW+1]);
    assign cur_miss = xlate_i.hit & ~cur_hit;       // tlb problems never fill

    // still the same line and still missing, nothing in flight
    assign req_fire = miss_q & cur_miss & (pline == miss_pline_q) & ~pend_q;

    //////////////////////////////
    // fill write
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_rsp_i.valid) begin
            valid_q[fill_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_rsp_i.valid) begin
            data_mem[fill_set] <= fill_rsp_i.data;
            tag_mem[fill_set]  <= fill_rsp_i.pline[PLW-1:SW+1];
        end
    end

    //////////////////////////////
    // lookup and miss control
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hit_q    <= 1'b0;
            miss_q   <= 1'b0;
            status_q <= '0;
            pend_q   <= 1'b0;
            req_q    <= 1'b0;
        end else begin
            hit_q          <= cur_hit;
            miss_q         <= cur_miss;
            status_q.miss  <= xlate_i.miss;
            status_q.fault <= xlate_i.fault;
            req_q          <= req_fire;               // one-cycle strobe
            if (fill_rsp_i.valid) begin
                pend_q <= 1'b0;
            end else if (req_fire) begin
                pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        vline_q      <= line_i;
        data_q       <= data_mem[set_idx];
        miss_pline_q <= pline;
        if (req_fire) begin
            req_pline_q <= miss_pline_q;
        end
    end

    assign line_o.valid     = hit_q;
    assign line_o.vline     = vline_q;
    assign line_o.data      = data_q;
    assign status_o         = status_q;
    assign fill_req_o.valid = req_q;
    assign fill_req_o.pline = req_pline_q;

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none
`include "fetch_consts.svh"

module fetch_unit (
    input  wire logic                 clk,
    input  wire logic                 arst_n_i,
    // control flow
    input  wire fetch_pkg::redirect_t init_i,
    input  wire fetch_pkg::redirect_t resteer_i,
    input  wire fetch_pkg::redirect_t predict_i,
    input  wire logic                 consume_even_i,
    input  wire logic                 consume_odd_i,
    // tlb load, shared by both copies
    input  wire fetch_pkg::tlb_wr_t   tlb_wr_i,
    // fill ports
    input  wire fetch_pkg::fill_rsp_t fill_rsp_even_i,
    input  wire fetch_pkg::fill_rsp_t fill_rsp_odd_i,
    output fetch_pkg::fill_req_t      fill_req_even_o,
    output fetch_pkg::fill_req_t      fill_req_odd_o,
    // decode side
    output fetch_pkg::fetch_line_t    line_even_o,
    output fetch_pkg::fetch_line_t    line_odd_o,
    output fetch_pkg::fetch_status_t  status_even_o,
    output fetch_pkg::fetch_status_t  status_odd_o
);

    logic [`FETCH_LINE_W-1:0] line_even;
    logic [`FETCH_LINE_W-1:0] line_odd;
    fetch_pkg::xlate_t        xlate_even;
    fetch_pkg::xlate_t        xlate_odd;

    //////////////////////////////
    // even bank
    //////////////////////////////
    fetch_addr_select #(.PARITY(0)) u_sel_even (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .init_i    (init_i),
        .resteer_i (resteer_i),
        .predict_i (predict_i),
        .consume_i (consume_even_i),
        .line_o    (line_even)
    );

    fetch_tlb u_tlb_even (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .tlb_wr_i  (tlb_wr_i),
        .line_i    (line_even),
        .xlate_o   (xlate_even)
    );

    icache_bank u_bank_even (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .line_i     (line_even),
        .xlate_i    (xlate_even),
        .fill_rsp_i (fill_rsp_even_i),
        .fill_req_o (fill_req_even_o),
        .line_o     (line_even_o),
        .status_o   (status_even_o)
    );

    //////////////////////////////
    // odd bank
    //////////////////////////////
    fetch_addr_select #(.PARITY(1)) u_sel_odd (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .init_i    (init_i),
        .resteer_i (resteer_i),
        .predict_i (predict_i),
        .consume_i (consume_odd_i),
        .line_o    (line_odd)
    );

    fetch_tlb u_tlb_odd (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .tlb_wr_i  (tlb_wr_i),
        .line_i    (line_odd),
        .xlate_o   (xlate_odd)
    );

    icache_bank u_bank_odd (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .line_i     (line_odd),
        .xlate_i    (xlate_odd),
        .fill_rsp_i (fill_rsp_odd_i),
        .fill_req_o (fill_req_odd_o),
        .line_o     (line_odd_o),
        .status_o   (status_odd_o)
    );

endmodule

`default_nettype wire

// ==== sim/fetch_tb.sv ====
`default_nettype none
`include "fetch_consts.svh"

module fetch_tb;

    logic                     clk;
    logic                     arst_n_i;
    fetch_pkg::redirect_t     init_i;
    fetch_pkg::redirect_t     resteer_i;
    fetch_pkg::redirect_t     predict_i;
    logic                     consume_even_i;
    logic                     consume_odd_i;
    fetch_pkg::tlb_wr_t       tlb_wr_i;
    fetch_pkg::fill_rsp_t     fill_rsp_even_i;
    fetch_pkg::fill_rsp_t     fill_rsp_odd_i;
    fetch_pkg::fill_req_t     fill_req_even_o;
    fetch_pkg::fill_req_t     fill_req_odd_o;
    fetch_pkg::fetch_line_t   line_even_o;
    fetch_pkg::fetch_line_t   line_odd_o;
    fetch_pkg::fetch_status_t status_even_o;
    fetch_pkg::fetch_status_t status_odd_o;

    fetch_pkg::tlb_entry_t    tlb_ref [`FETCH_TLB_N];   // software view of the tlb
    logic [`FETCH_LINE_W-1:0] exp_even;                 // model fetch registers
    logic [`FETCH_LINE_W-1:0] exp_odd;
    int                       req_cnt [2];
    int                       value_errs;
    int                       other_errs;

    fetch_unit UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic logic [`FETCH_LINE_W-1:0] split_line(input logic [31:0] addr,
                                                            input bit odd);
        fetch_pkg::fetch_va_u va;
        va = addr;
        if (!addr[4]) begin
            return odd ? va.line.lnum + 28'd1 : va.line.lnum;   // even line addressed
        end else begin
            return odd ? va.line.lnum : va.line.lnum + 28'd1;
        end
    endfunction

    function automatic fetch_pkg::xlate_t ref_xlate(input logic [`FETCH_LINE_W-1:0] lnum);
        fetch_pkg::xlate_t    r;
        fetch_pkg::fetch_va_u va;
        r = '0;
        r.miss = 1'b1;
        va.line.lnum = lnum;
        va.line.byte_sel = '0;
        for (int i = 0; i < `FETCH_TLB_N; i++) begin
            if (r.miss && tlb_ref[i].valid && tlb_ref[i].present
                    && tlb_ref[i].vpn == va.page.vpn) begin
                r.miss  = 1'b0;
                r.fault = tlb_ref[i].pcd;
                r.hit   = !tlb_ref[i].pcd;
                r.pfn   = tlb_ref[i].pfn;
            end
        end
        return r;
    endfunction

    // memory image seen through the fill port
    function automatic logic [`FETCH_LINE_BITS-1:0] ref_data(input logic [`FETCH_PLINE_W-1:0] pl);
        return {4{12'h5A3, pl}} ^ 128'h0F1E_2D3C_4B5A_6978_8796_A5B4_C3D2_E1F0;
    endfunction

    function automatic fetch_pkg::redirect_t jump(input bit on, input logic [31:0] addr);
        fetch_pkg::redirect_t r;
        r = '0;
        if (on) begin
            r = {1'b1, addr};
        end
        return r;
    endfunction

    function automatic logic [31:0] rand_addr(input bit safe);
        logic [19:0] vpn;
        case ($urandom % (safe ? 2 : 4))
            0:       vpn = 20'h00000;
            1:       vpn = 20'h00001;
            2:       vpn = 20'h00002;
            default: vpn = 20'h00010;
        endcase
        return {vpn, 12'($urandom)};
    endfunction

    //////////////////////////////
    // drivers and checks
    //////////////////////////////
    task automatic expect_eq(input string name, input logic [127:0] want,
                             input logic [127:0] got);
        if (want !== got) begin
            $display("Fail %s: expected %0h, actual %0h", name, want, got);
            value_errs++;
        end
    endtask

    task automatic load_tlb(input int idx, input logic pr, input logic pcd,
                            input logic [19:0] vpn, input logic [11:0] pfn);
        fetch_pkg::tlb_wr_t w;
        w = {1'b1, idx[2:0], 1'b1, pr, pcd, vpn, pfn};
        @(posedge clk);
        tlb_wr_i <= w;
        tlb_ref[idx] = w.entry;
        @(posedge clk);
        tlb_wr_i <= '0;
    endtask

    task automatic apply_redirect(input fetch_pkg::redirect_t ini,
                                  input fetch_pkg::redirect_t res,
                                  input fetch_pkg::redirect_t pre);
        fetch_pkg::redirect_t pick;
        @(posedge clk);
        init_i    <= ini;
        resteer_i <= res;
        predict_i <= pre;
        if (ini.valid) pick = ini;
        else if (res.valid) pick = res;
        else pick = pre;
        if (pick.valid) begin
            exp_even = split_line(pick.addr, 1'b0);
            exp_odd  = split_line(pick.addr, 1'b1);
        end
        @(posedge clk);
        init_i    <= '0;
        resteer_i <= '0;
        predict_i <= '0;
    endtask

    task automatic advance(input logic ce, input logic co);
        @(posedge clk);
        consume_even_i <= ce;
        consume_odd_i  <= co;
        if (ce) exp_even = exp_even + 28'd2;    // same parity, next window
        if (co) exp_odd = exp_odd + 28'd2;
        @(posedge clk);
        consume_even_i <= 1'b0;
        consume_odd_i  <= 1'b0;
    endtask

    // line number and status of the registered lookup
    task automatic check_window(input string name);
        fetch_pkg::xlate_t xe;
        fetch_pkg::xlate_t xo;
        @(posedge clk);
        @(negedge clk);
        xe = ref_xlate(exp_even);
        xo = ref_xlate(exp_odd);
        expect_eq({name, " even line"}, exp_even, line_even_o.vline);
        expect_eq({name, " odd line"}, exp_odd, line_odd_o.vline);
        expect_eq({name, " even status"}, {xe.miss, xe.fault}, status_even_o);
        expect_eq({name, " odd status"}, {xo.miss, xo.fault}, status_odd_o);
    endtask

    task automatic wait_valid(input string name);
        fetch_pkg::xlate_t xe;
        fetch_pkg::xlate_t xo;
        int                n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(line_even_o.valid && line_odd_o.valid) && n < 200);
        if (!(line_even_o.valid && line_odd_o.valid)) begin
            $display("%s: lines did not become valid within 200 cycles", name);
            other_errs++;
        end else begin
            xe = ref_xlate(exp_even);
            xo = ref_xlate(exp_odd);
            expect_eq({name, " even line"}, exp_even, line_even_o.vline);
            expect_eq({name, " odd line"}, exp_odd, line_odd_o.vline);
            expect_eq({name, " even data"}, ref_data({xe.pfn, exp_even[7:0]}), line_even_o.data);
            expect_eq({name, " odd data"}, ref_data({xo.pfn, exp_odd[7:0]}), line_odd_o.data);
        end
    endtask

    // no line and no fill while translation fails
    task automatic quiet_check(input string name);
        int snap_e;
        int snap_o;
        @(posedge clk);
        snap_e = req_cnt[0];
        snap_o = req_cnt[1];
        repeat (20) begin
            @(negedge clk);
            expect_eq({name, " line valid"}, 2'b00, {line_even_o.valid, line_odd_o.valid});
        end
        @(posedge clk);
        expect_eq({name, " even fills"}, snap_e, req_cnt[0]);
        expect_eq({name, " odd fills"}, snap_o, req_cnt[1]);
    endtask

    task automatic check_line(input fetch_pkg::fetch_line_t ln, input bit odd);
        fetch_pkg::xlate_t x;
        if (ln.valid) begin
            x = ref_xlate(ln.vline);
            if (ln.vline[0] != odd) begin
                $display("monitor: line %0h shows up in the wrong bank", ln.vline);
                other_errs++;
            end else if (!x.hit) begin
                $display("monitor: line %0h valid without a translation", ln.vline);
                other_errs++;
            end else begin
                expect_eq($sformatf("monitor data of line %0h", ln.vline),
                          ref_data({x.pfn, ln.vline[7:0]}), ln.data);
            end
        end
    endtask

    // the request carries the physical line of the lookup shown on the line output
    task automatic compare_fill(input string bank, input fetch_pkg::fill_req_t rq,
                                input logic [`FETCH_LINE_W-1:0] vl);
        fetch_pkg::xlate_t x;
        x = ref_xlate(vl);
        expect_eq({"monitor ", bank, " fill line"}, {x.pfn, vl[7:0]}, rq.pline);
    endtask

    //////////////////////////////
    // fill responders and compare
    //////////////////////////////
    initial begin : even_responder
        logic [`FETCH_PLINE_W-1:0] pl;
        forever begin
            @(negedge clk);
            if (fill_req_even_o.valid) begin
                pl = fill_req_even_o.pline;
                repeat (1 + $urandom % 8) @(posedge clk);
                fill_rsp_even_i <= {1'b1, pl, ref_data(pl)};
                @(posedge clk);
                fill_rsp_even_i <= '0;
            end
        end
    end

    initial begin : odd_responder
        logic [`FETCH_PLINE_W-1:0] pl;
        forever begin
            @(negedge clk);
            if (fill_req_odd_o.valid) begin
                pl = fill_req_odd_o.pline;
                repeat (1 + $urandom % 8) @(posedge clk);
                fill_rsp_odd_i <= {1'b1, pl, ref_data(pl)};
                @(posedge clk);
                fill_rsp_odd_i <= '0;
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n_i) begin
            if (fill_req_even_o.valid) begin
                req_cnt[0] = req_cnt[0] + 1;
                compare_fill("even", fill_req_even_o, line_even_o.vline);
            end
            if (fill_req_odd_o.valid) begin
                req_cnt[1] = req_cnt[1] + 1;
                compare_fill("odd", fill_req_odd_o, line_odd_o.vline);
            end
            check_line(line_even_o, 1'b0);
            check_line(line_odd_o, 1'b1);
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin : main_seq
        int unsigned pick;
        int unsigned mask;
        int          snap_e;
        int          snap_o;
        logic        ce;
        arst_n_i        = 1'b0;
        init_i          = '0;
        resteer_i       = '0;
        predict_i       = '0;
        consume_even_i  = 1'b0;
        consume_odd_i   = 1'b0;
        tlb_wr_i        = '0;
        fill_rsp_even_i = '0;
        fill_rsp_odd_i  = '0;
        value_errs      = 0;
        other_errs      = 0;
        req_cnt[0]      = 0;
        req_cnt[1]      = 0;
        for (int i = 0; i < `FETCH_TLB_N; i++) tlb_ref[i] = '0;
        void'($urandom(32'h5795));

        // reset
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (line_even_o.valid || line_odd_o.valid || fill_req_even_o.valid
                    || fill_req_odd_o.valid || status_even_o != '0 || status_odd_o != '0) begin
                $display("reset: an output is active while reset is asserted");
                other_errs++;
            end
        end
        @(posedge clk);
        arst_n_i <= 1'b1;
        exp_even = 28'd0;
        exp_odd  = 28'd1;
        repeat (8) begin
            @(negedge clk);
            expect_eq("after reset valid and fill", 4'b0000, {line_even_o.valid,
                      line_odd_o.valid, fill_req_even_o.valid, fill_req_odd_o.valid});
        end
        check_window("after reset");    // empty tlb, so a translation miss

        load_tlb(0, 1'b1, 1'b0, 20'h00000, 12'h001);
        load_tlb(1, 1'b1, 1'b0, 20'h00001, 12'h2A5);
        load_tlb(2, 1'b1, 1'b0, 20'h00002, 12'h013);
        load_tlb(3, 1'b1, 1'b0, 20'h00010, 12'h7F0);
        load_tlb(4, 1'b1, 1'b1, 20'h00020, 12'h100);    // device page
        load_tlb(5, 1'b0, 1'b0, 20'h00030, 12'h0C4);    // not present
        load_tlb(6, 1'b1, 1'b0, 20'h00001, 12'h3FF);    // shadowed by entry 1

        // init split
        apply_redirect(jump(1, 32'h0000_1000), '0, '0);
        check_window("init bit4 clear");
        wait_valid("init bit4 clear");
        apply_redirect(jump(1, 32'h0000_0FF0), '0, '0);  // window crosses a page
        check_window("init bit4 set");
        wait_valid("init bit4 set");
        apply_redirect(jump(1, 32'h0000_1010), '0, '0);
        check_window("init bit4 set same page");
        wait_valid("init bit4 set same page");

        // priority and sequencing
        apply_redirect(jump(1, 32'h0000_1000), jump(1, 32'h0000_2020), jump(1, 32'h0001_0040));
        check_window("priority all three");
        apply_redirect('0, jump(1, 32'h0000_2020), jump(1, 32'h0001_0040));
        check_window("priority resteer over predict");
        apply_redirect(jump(1, 32'h0001_0040), jump(1, 32'h0000_1000), '0);
        check_window("priority init over resteer");
        apply_redirect('0, '0, jump(1, 32'h0000_2060));
        check_window("predict alone");
        advance(1'b1, 1'b0);
        check_window("consume even");
        advance(1'b0, 1'b1);
        advance(1'b1, 1'b1);
        check_window("consume both");
        wait_valid("sequential fetch");

        // translation exceptions
        apply_redirect(jump(1, 32'h0004_0000), '0, '0);
        check_window("unmapped page");
        quiet_check("unmapped page");
        apply_redirect('0, jump(1, 32'h0002_0000), '0);
        check_window("uncached page");
        quiet_check("uncached page");
        apply_redirect('0, '0, jump(1, 32'h0003_0000));
        check_window("page not present");
        quiet_check("page not present");

        // hit after fill, then replacement in the same sets
        apply_redirect(jump(1, 32'h0000_0000), '0, '0);
        check_window("line zero");
        wait_valid("line zero");
        apply_redirect(jump(1, 32'h0000_0040), '0, '0);  // other sets, line zero stays
        check_window("move away");
        wait_valid("move away");
        @(posedge clk);
        snap_e = req_cnt[0];
        snap_o = req_cnt[1];
        apply_redirect(jump(1, 32'h0000_0000), '0, '0);
        check_window("refetch");
        wait_valid("refetch");
        @(posedge clk);
        expect_eq("refetch even fills", snap_e, req_cnt[0]);
        expect_eq("refetch odd fills", snap_o, req_cnt[1]);
        apply_redirect(jump(1, 32'h0000_0200), '0, '0);  // same sets, other tag
        check_window("same set other tag");
        wait_valid("same set other tag");
        @(posedge clk);
        snap_e = req_cnt[0];
        snap_o = req_cnt[1];
        apply_redirect(jump(1, 32'h0000_0000), '0, '0);
        check_window("replaced line");
        wait_valid("replaced line");
        @(posedge clk);
        expect_eq("replaced line even fills", snap_e + 1, req_cnt[0]);
        expect_eq("replaced line odd fills", snap_o + 1, req_cnt[1]);

        // random run
        for (int i = 0; i < 300; i++) begin
            pick = $urandom % 4;
            case (pick)
                0: begin
                    mask = 1 + $urandom % 7;
                    apply_redirect(jump(mask[0], rand_addr(0)), jump(mask[1], rand_addr(0)),
                                   jump(mask[2], rand_addr(0)));
                    check_window("random redirect");
                end
                1: begin
                    ce = 1'($urandom % 2);
                    advance(ce, !ce | 1'($urandom % 2));
                    check_window("random consume");
                end
                2: repeat (1 + $urandom % 6) @(posedge clk);
                default: begin
                    apply_redirect('0, jump(1, rand_addr(1)), '0);
                    check_window("random mapped redirect");
                    wait_valid("random mapped redirect");
                end
            endcase
        end
        repeat (20) @(posedge clk);    // let the last fills drain

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/fetch_pkg.sv
design/fetch_addr_select.sv
design/fetch_tlb.sv
design/icache_bank.sv
design/fetch_unit.sv
sim/fetch_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = fetch_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
PASS_MSG = === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
